// File: common/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Data and address width of the core.
`define CORE_XLEN 32

// Architectural register count. The index width follows as $clog2 of this.
`define CORE_REGS 32

// First fetch address after reset.
`define CORE_RESET_PC 32'h0000_0000

// Width of the LED mirror of x1.
`define CORE_LED_W 6

`endif

// File: common/core_pkg.sv
`default_nettype none

package core_pkg;

  // RV32I major opcodes, instr[6:0].
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011
  } opcode_e;

  // Encoded as {funct7[5], funct3} where the ISA allows it.
  typedef enum logic [3:0] {
    ALU_ADD    = 4'b0000,
    ALU_SUB    = 4'b1000,
    ALU_SLL    = 4'b0001,
    ALU_SLT    = 4'b0010,
    ALU_SLTU   = 4'b0011,
    ALU_XOR    = 4'b0100,
    ALU_SRL    = 4'b0101,
    ALU_SRA    = 4'b1101,
    ALU_OR     = 4'b0110,
    ALU_AND    = 4'b0111,
    ALU_PASS_B = 4'b1111   // LUI.
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_EQ   = 3'b000,
    BR_NE   = 3'b001,
    BR_NONE = 3'b010,      // Reserved funct3 slot, never taken.
    BR_LT   = 3'b100,
    BR_GE   = 3'b101,
    BR_LTU  = 3'b110,
    BR_GEU  = 3'b111
  } branch_cond_e;

  typedef enum logic {OP1_REG, OP1_PC} op1_sel_e;
  typedef enum logic {OP2_REG, OP2_IMM} op2_sel_e;
  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC_PLUS4} wb_sel_e;
  typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JAL, PC_JALR} pc_sel_e;

endpackage

`default_nettype wire

// File: common/decoded_ctrl_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

interface decoded_ctrl_if;

  logic [$clog2(`CORE_REGS)-1:0] rs1;
  logic [$clog2(`CORE_REGS)-1:0] rs2;
  logic [$clog2(`CORE_REGS)-1:0] rd;
  logic [`CORE_XLEN-1:0]         imm;

  core_pkg::alu_op_e      alu_op;
  core_pkg::op1_sel_e     op1_sel;
  core_pkg::op2_sel_e     op2_sel;
  core_pkg::branch_cond_e branch_cond;
  core_pkg::pc_sel_e      pc_sel;
  core_pkg::wb_sel_e      wb_sel;

  logic rd_wen;
  logic mem_wen;   // Doubles as the data memory write strobe.

  modport dec (output rs1, rs2, rd, imm, alu_op, op1_sel, op2_sel,
               branch_cond, pc_sel, wb_sel, rd_wen, mem_wen);

  modport exe (input imm, op1_sel, op2_sel, alu_op, branch_cond, pc_sel,
               mem_wen, rs1, rs2);

  modport res (input rd, rd_wen, wb_sel, rs1, rs2);

endinterface

`default_nettype wire

// File: decode/instr_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module instr_decode (
  input wire logic                  clk,
  input wire logic                  rst_n,
  input wire logic [`CORE_XLEN-1:0] instr,
  decoded_ctrl_if.dec               ctrl
);

  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [`CORE_XLEN-1:0] imm_i;
  logic [`CORE_XLEN-1:0] imm_s;
  logic [`CORE_XLEN-1:0] imm_b;
  logic [`CORE_XLEN-1:0] imm_u;
  logic [`CORE_XLEN-1:0] imm_j;

  // Maps funct3 and the alternate bit (instr[30]) to an ALU operation.
  function automatic core_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  alu_decode = alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
      3'b001:  alu_decode = core_pkg::ALU_SLL;
      3'b010:  alu_decode = core_pkg::ALU_SLT;
      3'b011:  alu_decode = core_pkg::ALU_SLTU;
      3'b100:  alu_decode = core_pkg::ALU_XOR;
      3'b101:  alu_decode = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
      3'b110:  alu_decode = core_pkg::ALU_OR;
      default: alu_decode = core_pkg::ALU_AND;
    endcase
  endfunction

  // ------------------------------
  // Fields and immediates
  // ------------------------------
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  assign ctrl.rs1 = instr[19:15];
  assign ctrl.rs2 = instr[24:20];
  assign ctrl.rd  = instr[11:7];

  // ------------------------------
  // Control decode
  // ------------------------------
  always_comb begin
    ctrl.imm         = '0;   // Defaults give a no-op.
    ctrl.alu_op      = core_pkg::ALU_ADD;
    ctrl.op1_sel     = core_pkg::OP1_REG;
    ctrl.op2_sel     = core_pkg::OP2_IMM;
    ctrl.branch_cond = core_pkg::BR_NONE;
    ctrl.pc_sel      = core_pkg::PC_SEQ;
    ctrl.wb_sel      = core_pkg::WB_ALU;
    ctrl.rd_wen      = 1'b0;
    ctrl.mem_wen     = 1'b0;

    case (opcode)
      core_pkg::OPC_OP: begin
        ctrl.op2_sel = core_pkg::OP2_REG;
        ctrl.alu_op  = alu_decode(funct3, instr[30]);
        ctrl.rd_wen  = 1'b1;
      end
      core_pkg::OPC_OP_IMM: begin
        ctrl.imm    = imm_i;
        ctrl.alu_op = alu_decode(funct3, (funct3 == 3'b101) && instr[30]);  // Only SRAI.
        ctrl.rd_wen = 1'b1;
      end
      core_pkg::OPC_LUI: begin
        ctrl.imm    = imm_u;
        ctrl.alu_op = core_pkg::ALU_PASS_B;
        ctrl.rd_wen = 1'b1;
      end
      core_pkg::OPC_AUIPC: begin
        ctrl.imm     = imm_u;
        ctrl.op1_sel = core_pkg::OP1_PC;
        ctrl.rd_wen  = 1'b1;
      end
      core_pkg::OPC_JAL: begin
        ctrl.imm     = imm_j;
        ctrl.op1_sel = core_pkg::OP1_PC;
        ctrl.pc_sel  = core_pkg::PC_JAL;
        ctrl.wb_sel  = core_pkg::WB_PC_PLUS4;
        ctrl.rd_wen  = 1'b1;
      end
      core_pkg::OPC_JALR: begin
        ctrl.imm    = imm_i;
        ctrl.pc_sel = core_pkg::PC_JALR;
        ctrl.wb_sel = core_pkg::WB_PC_PLUS4;
        ctrl.rd_wen = 1'b1;
      end
      core_pkg::OPC_BRANCH: begin
        ctrl.imm     = imm_b;
        ctrl.op1_sel = core_pkg::OP1_PC;   // ALU forms the target.
        ctrl.pc_sel  = core_pkg::PC_BRANCH;
        case (funct3)
          3'b000:  ctrl.branch_cond = core_pkg::BR_EQ;
          3'b001:  ctrl.branch_cond = core_pkg::BR_NE;
          3'b100:  ctrl.branch_cond = core_pkg::BR_LT;
          3'b101:  ctrl.branch_cond = core_pkg::BR_GE;
          3'b110:  ctrl.branch_cond = core_pkg::BR_LTU;
          3'b111:  ctrl.branch_cond = core_pkg::BR_GEU;
          default: ctrl.branch_cond = core_pkg::BR_NONE;
        endcase
      end
      core_pkg::OPC_LOAD: begin
        ctrl.imm    = imm_i;   // Word loads only.
        ctrl.wb_sel = core_pkg::WB_MEM;
        ctrl.rd_wen = 1'b1;
      end
      core_pkg::OPC_STORE: begin
        ctrl.imm     = imm_s;
        ctrl.mem_wen = 1'b1;
      end
      default: ;
    endcase

    if (!rst_n) begin
      ctrl.rd_wen  = 1'b0;
      ctrl.mem_wen = 1'b0;
    end
  end

  a_opcode_known: assert property (@(posedge clk) disable iff (!rst_n)
    opcode inside {core_pkg::OPC_OP, core_pkg::OPC_OP_IMM, core_pkg::OPC_LUI,
                   core_pkg::OPC_AUIPC, core_pkg::OPC_JAL, core_pkg::OPC_JALR,
                   core_pkg::OPC_BRANCH, core_pkg::OPC_LOAD, core_pkg::OPC_STORE})
    else $error("Unknown opcode %b fetched", opcode);

endmodule

`default_nettype wire

// File: execute/execute_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module execute_unit (
  input wire logic                   clk,
  input wire logic                   rst_n,
  decoded_ctrl_if.exe                ctrl,
  input wire logic [`CORE_XLEN-1:0]  rs1_data,
  input wire logic [`CORE_XLEN-1:0]  rs2_data,
  output logic     [`CORE_XLEN-1:0]  pc,
  output logic     [`CORE_XLEN-1:0]  pc_plus4,
  output logic     [`CORE_XLEN-1:0]  alu_out
);

  localparam logic [`CORE_XLEN-1:0] insn_bytes = 4;

  logic [`CORE_XLEN-1:0] op_a;
  logic [`CORE_XLEN-1:0] op_b;
  logic [4:0]            shamt;
  logic                  taken;
  logic [`CORE_XLEN-1:0] pc_next;

  // ------------------------------
  // Operands and ALU
  // ------------------------------
  assign op_a  = (ctrl.op1_sel == core_pkg::OP1_PC) ? pc : rs1_data;
  assign op_b  = (ctrl.op2_sel == core_pkg::OP2_IMM) ? ctrl.imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (ctrl.alu_op)
      core_pkg::ALU_ADD:    alu_out = op_a + op_b;
      core_pkg::ALU_SUB:    alu_out = op_a - op_b;
      core_pkg::ALU_SLL:    alu_out = op_a << shamt;
      core_pkg::ALU_SLT:    alu_out = {{(`CORE_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      core_pkg::ALU_SLTU:   alu_out = {{(`CORE_XLEN-1){1'b0}}, op_a < op_b};
      core_pkg::ALU_XOR:    alu_out = op_a ^ op_b;
      core_pkg::ALU_SRL:    alu_out = op_a >> shamt;
      core_pkg::ALU_SRA:    alu_out = $unsigned($signed(op_a) >>> shamt);
      core_pkg::ALU_OR:     alu_out = op_a | op_b;
      core_pkg::ALU_AND:    alu_out = op_a & op_b;
      core_pkg::ALU_PASS_B: alu_out = op_b;
      default:              alu_out = op_a + op_b;
    endcase
  end

  // Branch compare always looks at the register values, never the ALU operands.
  always_comb begin
    case (ctrl.branch_cond)
      core_pkg::BR_EQ:  taken = (rs1_data == rs2_data);
      core_pkg::BR_NE:  taken = (rs1_data != rs2_data);
      core_pkg::BR_LT:  taken = ($signed(rs1_data) <  $signed(rs2_data));
      core_pkg::BR_GE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      core_pkg::BR_LTU: taken = (rs1_data <  rs2_data);
      core_pkg::BR_GEU: taken = (rs1_data >= rs2_data);
      default:          taken = 1'b0;
    endcase
  end

  // ------------------------------
  // Program counter
  // ------------------------------
  assign pc_plus4 = pc + insn_bytes;

  always_comb begin
    case (ctrl.pc_sel)
      core_pkg::PC_BRANCH: pc_next = taken ? alu_out : pc_plus4;
      core_pkg::PC_JAL:    pc_next = alu_out;
      core_pkg::PC_JALR:   pc_next = {alu_out[`CORE_XLEN-1:1], 1'b0};
      default:             pc_next = pc_plus4;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= `CORE_RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    pc[1:0] == 2'b00)
    else $error("PC %h is not word aligned", pc);

  // Only word stores exist, so the address computed from rs1 and the offset must be aligned.
  a_store_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl.mem_wen |-> (alu_out[1:0] == 2'b00))
    else $error("Store to x%0d+imm gives unaligned address %h", ctrl.rs1, alu_out);

endmodule

`default_nettype wire

// File: result/result_regfile.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module result_regfile (
  input wire logic                   clk,
  input wire logic                   rst_n,
  decoded_ctrl_if.res                ctrl,
  input wire logic [`CORE_XLEN-1:0]  alu_out,
  input wire logic [`CORE_XLEN-1:0]  mem_rdata,
  input wire logic [`CORE_XLEN-1:0]  pc_plus4,
  output logic     [`CORE_XLEN-1:0]  rs1_data,
  output logic     [`CORE_XLEN-1:0]  rs2_data,
  output logic     [`CORE_LED_W-1:0] leds
);

  localparam int reg_aw = $clog2(`CORE_REGS);

  logic [`CORE_XLEN-1:0] regs [0:`CORE_REGS-1];
  logic [`CORE_XLEN-1:0] wb_data;
  logic                  wen;

  // ------------------------------
  // Write-back
  // ------------------------------
  always_comb begin
    case (ctrl.wb_sel)
      core_pkg::WB_MEM:      wb_data = mem_rdata;
      core_pkg::WB_PC_PLUS4: wb_data = pc_plus4;   // Link value.
      default:               wb_data = alu_out;
    endcase
  end

  assign wen = ctrl.rd_wen && (ctrl.rd != '0);   // x0 is never written.

  // The whole file clears in reset, so entry 0 holds zero from then on.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `CORE_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen) begin
      regs[ctrl.rd] <= wb_data;
    end
  end

  assign rs1_data = regs[ctrl.rs1];
  assign rs2_data = regs[ctrl.rs2];

  // ------------------------------
  // LED mirror of x1
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      leds <= '0;
    end else if (wen && (ctrl.rd == reg_aw'(1))) begin
      leds <= wb_data[`CORE_LED_W-1:0];
    end
  end

  // A load from undriven memory would put an unknown value into the file.
  a_wb_known: assert property (@(posedge clk) disable iff (!rst_n)
    wen |-> !$isunknown(wb_data))
    else $error("Write of x%0d carries an unknown value", ctrl.rd);

endmodule

`default_nettype wire

// File: src/rv_core_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module rv_core_top (
  input wire logic                   clk,
  input wire logic                   rst_n,
  output logic     [`CORE_XLEN-1:0]  imem_addr,
  input wire logic [`CORE_XLEN-1:0]  imem_data,
  output logic     [`CORE_XLEN-1:0]  dmem_addr,
  output logic     [`CORE_XLEN-1:0]  dmem_wdata,
  output logic                       dmem_wen,
  input wire logic [`CORE_XLEN-1:0]  dmem_rdata,
  output logic     [`CORE_LED_W-1:0] leds
);

  logic [`CORE_XLEN-1:0] rs1_data;
  logic [`CORE_XLEN-1:0] rs2_data;
  logic [`CORE_XLEN-1:0] alu_out;
  logic [`CORE_XLEN-1:0] pc_plus4;

  decoded_ctrl_if ctrl ();

  instr_decode u_decode (
    .clk   (clk),
    .rst_n (rst_n),
    .instr (imem_data),
    .ctrl  (ctrl.dec)
  );

  execute_unit u_execute (
    .clk      (clk),
    .rst_n    (rst_n),
    .ctrl     (ctrl.exe),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .pc       (imem_addr),   // Fetch address is the PC itself.
    .pc_plus4 (pc_plus4),
    .alu_out  (alu_out)
  );

  result_regfile u_result (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl      (ctrl.res),
    .alu_out   (alu_out),
    .mem_rdata (dmem_rdata),
    .pc_plus4  (pc_plus4),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .leds      (leds)
  );

  assign dmem_addr  = alu_out;
  assign dmem_wdata = rs2_data;
  assign dmem_wen   = ctrl.mem_wen;

endmodule

`default_nettype wire

// File: verif/core_ref_model.svh
`ifndef CORE_REF_MODEL_SVH
`define CORE_REF_MODEL_SVH

// Architectural state of the model, kept apart from the DUT.
logic [`CORE_XLEN-1:0]  model_regs [0:`CORE_REGS-1];
logic [`CORE_XLEN-1:0]  model_pc;
logic [`CORE_LED_W-1:0] model_leds;
logic [`CORE_XLEN-1:0]  model_dmem [0:255];

// Initial data word for a word index. Every index bit shows up in the word.
function automatic logic [31:0] fill_word(input int idx);
  return {idx[7:0], ~idx[7:0], idx[7:0] ^ 8'h5A, 8'hC3};
endfunction

task automatic model_reset();
  for (int i = 0; i < `CORE_REGS; i++) begin
    model_regs[i] = '0;
  end
  for (int i = 0; i < 256; i++) begin
    model_dmem[i] = fill_word(i);
  end
  model_pc   = `CORE_RESET_PC;
  model_leds = '0;
endtask

// Integer operation picked by funct3, alt is instr[30] where the ISA uses it.
function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
  case (f3)
    3'd0:    return alt ? a - b : a + b;
    3'd1:    return a << b[4:0];
    3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3:    return (a < b) ? 32'd1 : 32'd0;
    3'd4:    return a ^ b;
    3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6:    return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
  case (f3)
    3'd0:    return a == b;
    3'd1:    return a != b;
    3'd4:    return $signed(a) < $signed(b);
    3'd5:    return $signed(a) >= $signed(b);
    3'd6:    return a < b;
    3'd7:    return a >= b;
    default: return 1'b0;
  endcase
endfunction

// Executes one instruction on the model state and returns the next PC.
function automatic logic [31:0] ref_step(input logic [31:0] instr, output logic st_en,
                                         output logic [31:0] st_addr,
                                         output logic [31:0] st_data);
  logic [4:0]  rd;
  logic [2:0]  f3;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm;
  logic [31:0] addr;
  logic [31:0] res;
  logic        wr;
  logic [31:0] next_pc;
  rd      = instr[11:7];
  f3      = instr[14:12];
  a       = model_regs[instr[19:15]];
  b       = model_regs[instr[24:20]];
  imm     = {{20{instr[31]}}, instr[31:20]};   // I-type unless replaced below.
  res     = '0;
  wr      = 1'b0;
  next_pc = model_pc + 32'd4;
  st_en   = 1'b0;
  st_addr = '0;
  st_data = '0;
  case (instr[6:0])
    core_pkg::OPC_OP: begin
      res = alu_ref(f3, instr[30], a, b);
      wr  = 1'b1;
    end
    core_pkg::OPC_OP_IMM: begin
      res = alu_ref(f3, (f3 == 3'd5) && instr[30], a, imm);
      wr  = 1'b1;
    end
    core_pkg::OPC_LUI: begin
      res = {instr[31:12], 12'b0};
      wr  = 1'b1;
    end
    core_pkg::OPC_AUIPC: begin
      res = model_pc + {instr[31:12], 12'b0};
      wr  = 1'b1;
    end
    core_pkg::OPC_JAL: begin
      imm     = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      res     = model_pc + 32'd4;
      wr      = 1'b1;
      next_pc = model_pc + imm;
    end
    core_pkg::OPC_JALR: begin
      res     = model_pc + 32'd4;
      wr      = 1'b1;
      next_pc = (a + imm) & ~32'd1;
    end
    core_pkg::OPC_BRANCH: begin
      imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      if (branch_ref(f3, a, b)) begin
        next_pc = model_pc + imm;
      end
    end
    core_pkg::OPC_LOAD: begin
      addr = a + imm;
      res  = model_dmem[addr[9:2]];
      wr   = 1'b1;
    end
    core_pkg::OPC_STORE: begin
      imm     = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      addr    = a + imm;
      st_en   = 1'b1;
      st_addr = addr;
      st_data = b;
      model_dmem[addr[9:2]] = b;
    end
    default: ;
  endcase
  if (wr && (rd != 5'd0)) begin
    model_regs[rd] = res;
    if (rd == 5'd1) begin
      model_leds = res[`CORE_LED_W-1:0];
    end
  end
  model_pc = next_pc;
  return next_pc;
endfunction

`endif

// File: verif/core_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module core_tb;

  localparam int timeout_cycles = 2000;

  logic                   clk;
  logic                   rst_n;
  logic                   start;
  logic [`CORE_XLEN-1:0]  imem_addr;
  logic [`CORE_XLEN-1:0]  imem_data;
  logic [`CORE_XLEN-1:0]  dmem_addr;
  logic [`CORE_XLEN-1:0]  dmem_wdata;
  logic                   dmem_wen;
  logic [`CORE_XLEN-1:0]  dmem_rdata;
  logic [`CORE_LED_W-1:0] leds;

  logic [31:0] imem [0:1023];
  logic [31:0] dmem [0:255];
  int          prog_len;
  int          cycles;
  integer      seed;
  logic [31:0] ctrl_start;
  logic [31:0] mem_start;
  logic [31:0] upper_start;
  logic [31:0] end_addr;
  logic        exp_st_en;
  logic [31:0] exp_st_addr;
  logic [31:0] exp_st_data;
  string       sect;

  `include "core_ref_model.svh"

  rv_core_top dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_wen   (dmem_wen),
    .dmem_rdata (dmem_rdata),
    .leds       (leds)
  );

  always #2 clk = ~clk;

  // ------------------------------
  // Memory models
  // ------------------------------
  assign imem_data  = imem[imem_addr[11:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    if (dmem_wen) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
    end
  end

  task automatic check_value(input string test_name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s: expected %h, actual %h", test_name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "Check %s failed", test_name);
    end
  endtask

  // ------------------------------
  // Instruction encoders
  // ------------------------------
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic emit(input logic [31:0] instr);
    imem[prog_len] = instr;
    prog_len++;
  endtask

  // ------------------------------
  // Program sections
  // ------------------------------
  task automatic build_alu_section();
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    for (int i = 0; i < 200; i++) begin
      f3  = $random(seed);
      alt = $random(seed);
      imm = $random(seed);
      rd  = $random(seed);
      rs1 = $random(seed);
      rs2 = $random(seed);
      if ($random(seed) & 1) begin
        alt = alt && ((f3 == 3'd0) || (f3 == 3'd5));   // SUB and SRA only.
        emit(enc_r({1'b0, alt, 5'd0}, rs2, rs1, f3, rd));
      end else begin
        if ((f3 == 3'd1) || (f3 == 3'd5)) begin
          imm = {1'b0, alt && (f3 == 3'd5), 5'd0, imm[4:0]};
        end
        emit(enc_i(imm, rs1, f3, rd, core_pkg::OPC_OP_IMM));
      end
    end
    for (int r = 0; r < `CORE_REGS; r++) begin
      emit(enc_s(12'(256 + 4 * r), 5'(r), 5'd0));
    end
  endtask

  // A taken branch skips the counter bump in x10, a not-taken one runs it.
  task automatic emit_branch_pair(input logic [2:0] f3, input logic [4:0] t1,
                                  input logic [4:0] t2, input logic [4:0] n1,
                                  input logic [4:0] n2);
    emit(enc_b(13'd8, t2, t1, f3));
    emit(enc_i(12'd1, 5'd10, 3'd0, 5'd10, core_pkg::OPC_OP_IMM));
    emit(enc_b(13'd8, n2, n1, f3));
    emit(enc_i(12'd1, 5'd10, 3'd0, 5'd10, core_pkg::OPC_OP_IMM));
  endtask

  task automatic build_control_section();
    ctrl_start = prog_len * 4;
    emit(enc_i(12'd5, 5'd0, 3'd0, 5'd5, core_pkg::OPC_OP_IMM));
    emit(enc_i(12'hFFD, 5'd0, 3'd0, 5'd6, core_pkg::OPC_OP_IMM));   // x6 = -3.
    emit(enc_i(12'd5, 5'd0, 3'd0, 5'd7, core_pkg::OPC_OP_IMM));
    emit(enc_i(12'd0, 5'd0, 3'd0, 5'd10, core_pkg::OPC_OP_IMM));
    emit_branch_pair(3'd0, 5'd5, 5'd7, 5'd5, 5'd6);
    emit_branch_pair(3'd1, 5'd5, 5'd6, 5'd5, 5'd7);
    emit_branch_pair(3'd4, 5'd6, 5'd5, 5'd5, 5'd6);
    emit_branch_pair(3'd5, 5'd5, 5'd6, 5'd6, 5'd5);
    emit_branch_pair(3'd6, 5'd5, 5'd6, 5'd6, 5'd5);
    emit_branch_pair(3'd7, 5'd6, 5'd5, 5'd5, 5'd6);
    emit(enc_s(12'h300, 5'd10, 5'd0));
    emit(enc_j(21'd8, 5'd1));
    emit(enc_i(12'd1, 5'd10, 3'd0, 5'd10, core_pkg::OPC_OP_IMM));
    emit(enc_u(20'd0, 5'd3, core_pkg::OPC_AUIPC));
    emit(enc_i(12'd13, 5'd3, 3'd0, 5'd2, core_pkg::OPC_JALR));   // The odd offset still lands on +12.
    emit(enc_i(12'd1, 5'd10, 3'd0, 5'd10, core_pkg::OPC_OP_IMM));
    emit(enc_s(12'h304, 5'd1, 5'd0));
    emit(enc_s(12'h308, 5'd2, 5'd0));
  endtask

  task automatic build_memory_section();
    mem_start = prog_len * 4;
    emit(enc_i(12'h200, 5'd0, 3'd0, 5'd11, core_pkg::OPC_OP_IMM));
    emit(enc_u(20'hDEADB, 5'd12, core_pkg::OPC_LUI));
    emit(enc_i(12'h6EF, 5'd12, 3'd0, 5'd12, core_pkg::OPC_OP_IMM));
    emit(enc_u(20'h13579, 5'd13, core_pkg::OPC_LUI));
    emit(enc_i(12'hBDF, 5'd13, 3'd0, 5'd13, core_pkg::OPC_OP_IMM));
    emit(enc_i(12'h7A5, 5'd0, 3'd0, 5'd14, core_pkg::OPC_OP_IMM));
    emit(enc_s(12'd0, 5'd12, 5'd11));
    emit(enc_s(12'd12, 5'd13, 5'd11));
    emit(enc_s(12'hFFC, 5'd14, 5'd11));
    emit(enc_i(12'd0, 5'd11, 3'b010, 5'd20, core_pkg::OPC_LOAD));
    emit(enc_i(12'd12, 5'd11, 3'b010, 5'd21, core_pkg::OPC_LOAD));
    emit(enc_i(12'hFFC, 5'd11, 3'b010, 5'd22, core_pkg::OPC_LOAD));
    emit(enc_s(12'h310, 5'd20, 5'd0));
    emit(enc_s(12'h314, 5'd21, 5'd0));
    emit(enc_s(12'h318, 5'd22, 5'd0));
  endtask

  task automatic build_upper_section();
    upper_start = prog_len * 4;
    emit(enc_u(20'hABCDE, 5'd15, core_pkg::OPC_LUI));
    emit(enc_u(20'h12345, 5'd16, core_pkg::OPC_AUIPC));
    emit(enc_s(12'h320, 5'd15, 5'd0));
    emit(enc_s(12'h324, 5'd16, 5'd0));
    emit(enc_i(12'd123, 5'd0, 3'd0, 5'd0, core_pkg::OPC_OP_IMM));
    emit(enc_u(20'hFFFFF, 5'd0, core_pkg::OPC_LUI));
    emit(enc_s(12'h328, 5'd0, 5'd0));   // Must store zero.
    end_addr = prog_len * 4;
    emit(enc_j(21'd0, 5'd0));
  endtask

  function automatic string section_of(input logic [31:0] pc);
    if (pc >= upper_start) begin
      return "upper";
    end else if (pc >= mem_start) begin
      return "memory";
    end else if (pc >= ctrl_start) begin
      return "control";
    end else begin
      return "alu";
    end
  endfunction

  // ------------------------------
  // Compare against the model
  // ------------------------------
  always @(negedge clk) begin
    if (start) begin
      sect = section_of(model_pc);
      check_value($sformatf("%s imem_addr", sect), model_pc, imem_addr);
      check_value($sformatf("%s leds", sect), model_leds, leds);
      void'(ref_step(imem[model_pc[11:2]], exp_st_en, exp_st_addr, exp_st_data));
      check_value($sformatf("%s dmem_wen", sect), exp_st_en, dmem_wen);
      if (exp_st_en) begin
        check_value($sformatf("%s store addr", sect), exp_st_addr, dmem_addr);
        check_value($sformatf("%s store data", sect), exp_st_data, dmem_wdata);
      end
    end
  end

  initial begin
    clk      = 1'b0;
    rst_n    = 1'b0;
    start    = 1'b0;
    seed     = 229;
    prog_len = 0;
    for (int i = 0; i < 1024; i++) begin
      imem[i] = enc_i(12'(i), 5'd0, 3'd0, 5'd0, core_pkg::OPC_OP_IMM);   // Harmless fill.
    end
    for (int i = 0; i < 256; i++) begin
      dmem[i] = fill_word(i);
    end
    emit(enc_s(12'h33C, 5'd0, 5'd0));   // A store sits at the reset PC while rst_n is low.
    build_alu_section();
    build_control_section();
    build_memory_section();
    build_upper_section();
    model_reset();

    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      check_value("reset imem_addr", `CORE_RESET_PC, imem_addr);
      check_value("reset dmem_wen", 32'd0, dmem_wen);
      check_value("reset leds", 32'd0, leds);
    end
    @(posedge clk);
    rst_n <= 1'b1;
    start <= 1'b1;

    cycles = 0;
    while ((imem_addr !== end_addr) && (cycles < timeout_cycles)) begin
      @(negedge clk);
      cycles++;
    end
    if (imem_addr !== end_addr) begin
      $display("ERROR: program never reached its end address %h in %0d cycles",
               end_addr, timeout_cycles);
      $display("Simulation failed");
      $fatal(1, "Timeout");
    end else begin
      repeat (2) @(posedge clk);
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+common
+incdir+verif
common/core_pkg.sv
common/decoded_ctrl_if.sv
decode/instr_decode.sv
execute/execute_unit.sv
result/result_regfile.sv
src/rv_core_top.sv
verif/core_tb.sv
